/* common/u2_ctrl_defs.svh */
/*
 * Settings bus address map and fixed constants of the control core.
 * Included by the decode, register, time and readback stages.
 */

`ifndef U2_CTRL_DEFS_SVH
`define U2_CTRL_DEFS_SVH

// Bank base addresses on the settings bus
`define SR_MISC_BASE      8'd0
`define SR_TIME64_BASE    8'd10

// Misc bank offsets, offset 5 is a hole
`define MISC_CLK          3'd0
`define MISC_SER          3'd1
`define MISC_ADC          3'd2
`define MISC_LED_SW       3'd3
`define MISC_PHY          3'd4
`define MISC_LED_SRC      3'd6
`define MISC_COUNT        8'd7

// Time bank offsets
`define TIME_HI           3'd0
`define TIME_LO           3'd1
`define TIME_CTRL         3'd2
`define TIME_COUNT        8'd3

// LEDs 1 to 4 under hardware control after reset
`define LED_SRC_RESET     8'h1E

// Bump when the register map changes (major, minor)
`define COMPAT_NUM        {16'd9, 16'd0}

`endif

/* common/settings_pkg.sv */
/*
 * Types of the settings bus and of the decoded write command.
 * Also holds the grouped clock, serdes and ADC control pins.
 */

`default_nettype none

package settings_pkg;

   typedef logic [7:0]  set_addr_t;
   typedef logic [31:0] set_data_t;
   typedef logic [2:0]  set_offset_t;
   typedef logic [3:0]  rb_addr_t;

   // Raw write as it arrives on the bus
   typedef struct packed {
      logic      stb;
      set_addr_t addr;
      set_data_t data;
   } set_bus_t;

   // Write after bank decode, at most one enable high
   typedef struct packed {
      logic        misc_we;
      logic        time_we;
      set_offset_t offset;
      set_data_t   data;
   } set_cmd_t;

   typedef struct packed {
      logic       clock_ready;
      logic [1:0] clk_en;
      logic [1:0] clk_sel;
      logic       ser_enable;
      logic       ser_prbsen;
      logic       ser_loopen;
      logic       ser_rx_en;
      logic       adc_oe_a;
      logic       adc_on_a;
      logic       adc_oe_b;
      logic       adc_on_b;
   } ctrl_pins_t;

endpackage

`default_nettype wire

/* common/timing_pkg.sv */
/*
 * Types for VITA time keeping.
 * Used by the time counter and the readback mux.
 */

`default_nettype none

package timing_pkg;

   typedef logic [63:0] vita_time_t;

   // Armed means the staged time goes in at the next PPS edge
   typedef enum logic {
      PPS_IDLE,
      PPS_ARMED
   } pps_load_e;

endpackage

`default_nettype wire

/* design/settings_ingress.sv */
/*
 * First stage of the control pipeline. Registers a settings bus write,
 * decodes the address against the misc and time banks and registers the
 * resulting command. Writes outside both banks are dropped.
 */

`timescale 1ns/1ps
`default_nettype none

`include "u2_ctrl_defs.svh"

module settings_ingress
   import settings_pkg::*;
(
   input  wire      dsp_clk,
   input  wire      por_rst,
   input  set_bus_t set_i,
   output set_cmd_t cmd_o
);

   logic        stb_q;
   set_addr_t   addr_q;
   set_data_t   data_q;

   set_addr_t   misc_rel;
   set_addr_t   time_rel;
   logic        misc_hit;
   logic        time_hit;

   logic        misc_we_q;
   logic        time_we_q;
   set_offset_t offset_q;
   set_data_t   cmd_data_q;

   // Input capture
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         stb_q <= 1'b0;
      end else begin
         stb_q <= set_i.stb;
      end
   end

   always_ff @(posedge dsp_clk) begin
      addr_q <= set_i.addr;
      data_q <= set_i.data;
   end

   // Relative address wraps below the base, so one compare per bank
   assign misc_rel = addr_q - `SR_MISC_BASE;
   assign time_rel = addr_q - `SR_TIME64_BASE;
   assign misc_hit = stb_q && (misc_rel < `MISC_COUNT);
   assign time_hit = stb_q && (time_rel < `TIME_COUNT);

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         misc_we_q <= 1'b0;
         time_we_q <= 1'b0;
      end else begin
         misc_we_q <= misc_hit;
         time_we_q <= time_hit;
      end
   end

   always_ff @(posedge dsp_clk) begin
      offset_q   <= misc_hit ? misc_rel[2:0] : time_rel[2:0];
      cmd_data_q <= data_q;
   end

   assign cmd_o.misc_we = misc_we_q;
   assign cmd_o.time_we = time_we_q;
   assign cmd_o.offset  = offset_q;
   assign cmd_o.data    = cmd_data_q;

endmodule

`default_nettype wire

/* design/misc_control.sv */
/*
 * Misc setting registers: clock, serdes and ADC control pins, PHY reset,
 * LED software value and LED source select. Each LED shows either a
 * hardware status bit or its software bit, chosen per LED.
 */

`timescale 1ns/1ps
`default_nettype none

`include "u2_ctrl_defs.svh"

module misc_control
   import settings_pkg::*;
(
   input  wire        dsp_clk,
   input  wire        por_rst,
   input  set_cmd_t   cmd_i,
   input  wire        run_rx_i,
   input  wire        run_tx_i,
   input  wire        clk_status_i,
   input  wire        serdes_link_up_i,
   input  wire        good_sync_i,
   output ctrl_pins_t ctrl_pins_o,
   output logic [7:0] leds_o,
   output logic       phy_resetn_o
);

   logic [4:0] clk_reg;
   logic [3:0] ser_reg;
   logic [3:0] adc_reg;
   logic [7:0] led_sw;
   logic [7:0] led_src;
   logic       phy_reset;
   logic [7:0] led_hw;

   ////////////////////
   // Register writes
   ////////////////////

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         clk_reg   <= '0;
         ser_reg   <= '0;
         adc_reg   <= '0;
         led_sw    <= '0;
         led_src   <= `LED_SRC_RESET;
         phy_reset <= 1'b0;
      end else if (cmd_i.misc_we) begin
         case (cmd_i.offset)
            `MISC_CLK:     clk_reg   <= cmd_i.data[4:0];
            `MISC_SER:     ser_reg   <= cmd_i.data[3:0];
            `MISC_ADC:     adc_reg   <= cmd_i.data[3:0];
            `MISC_LED_SW:  led_sw    <= cmd_i.data[7:0];
            `MISC_PHY:     phy_reset <= cmd_i.data[0];
            `MISC_LED_SRC: led_src   <= cmd_i.data[7:0];
            default: begin
            end
         endcase
      end
   end

   ////////////////////
   // Pin mapping
   ////////////////////

   assign ctrl_pins_o.clock_ready = clk_reg[4];
   assign ctrl_pins_o.clk_en      = clk_reg[3:2];
   assign ctrl_pins_o.clk_sel     = clk_reg[1:0];
   assign ctrl_pins_o.ser_enable  = ser_reg[3];
   assign ctrl_pins_o.ser_prbsen  = ser_reg[2];
   assign ctrl_pins_o.ser_loopen  = ser_reg[1];
   assign ctrl_pins_o.ser_rx_en   = ser_reg[0];
   assign ctrl_pins_o.adc_oe_a    = adc_reg[3];
   assign ctrl_pins_o.adc_on_a    = adc_reg[2];
   assign ctrl_pins_o.adc_oe_b    = adc_reg[1];
   assign ctrl_pins_o.adc_on_b    = adc_reg[0];

   // PHY pin is active low
   assign phy_resetn_o = ~phy_reset;

   ////////////////////
   // LED mux
   ////////////////////

   // Link LED only lights once time is locked to PPS
   assign led_hw = {3'b000, run_tx_i, run_rx_i, clk_status_i,
                    serdes_link_up_i & good_sync_i, 1'b0};

   // Source bit 1 picks hardware, 0 picks software
   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

endmodule

`default_nettype wire

/* time/vita_time_keeper.sv */
/*
 * 64-bit VITA time counter. Loads the staged time at once or at the next
 * PPS rising edge, captures the time at every PPS edge and pulses an
 * interrupt. good_sync rises on the first armed PPS load.
 */

`timescale 1ns/1ps
`default_nettype none

`include "u2_ctrl_defs.svh"

module vita_time_keeper
   import settings_pkg::*;
   import timing_pkg::*;
(
   input  wire        dsp_clk,
   input  wire        por_rst,
   input  set_cmd_t   cmd_i,
   input  wire        pps_i,
   output vita_time_t vita_time_o,
   output vita_time_t vita_time_pps_o,
   output logic       good_sync_o,
   output logic       pps_int_o
);

   set_data_t  time_hi;
   set_data_t  time_lo;
   pps_load_e  load_state;
   vita_time_t vita_time;
   vita_time_t vita_time_pps;

   logic       pps_meta;
   logic       pps_sync;
   logic       pps_prev;
   logic       pps_edge;
   logic       ctrl_we;
   logic       load_now;
   logic       pps_load;

   // Staged time words
   always_ff @(posedge dsp_clk) begin
      if (cmd_i.time_we && (cmd_i.offset == `TIME_HI)) begin
         time_hi <= cmd_i.data;
      end
      if (cmd_i.time_we && (cmd_i.offset == `TIME_LO)) begin
         time_lo <= cmd_i.data;
      end
   end

   assign ctrl_we  = cmd_i.time_we && (cmd_i.offset == `TIME_CTRL);
   assign load_now = ctrl_we && cmd_i.data[0];

   ////////////////////
   // PPS edge detect
   ////////////////////

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         pps_meta <= 1'b0;
         pps_sync <= 1'b0;
         pps_prev <= 1'b0;
      end else begin
         pps_meta <= pps_i;
         pps_sync <= pps_meta;
         pps_prev <= pps_sync;
      end
   end

   assign pps_edge = pps_sync & ~pps_prev;
   assign pps_load = pps_edge && (load_state == PPS_ARMED);

   // Load FSM
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         load_state <= PPS_IDLE;
      end else begin
         case (load_state)
            PPS_IDLE: begin
               if (ctrl_we && !cmd_i.data[0]) begin
                  load_state <= PPS_ARMED;
               end
            end
            PPS_ARMED: begin
               if (pps_edge) begin
                  load_state <= PPS_IDLE;
               end
            end
            default: load_state <= PPS_IDLE;
         endcase
      end
   end

   ////////////////////
   // Counter and capture
   ////////////////////

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         vita_time <= '0;
      end else if (load_now || pps_load) begin
         vita_time <= {time_hi, time_lo};
      end else begin
         vita_time <= vita_time + 64'd1;
      end
   end

   // Capture holds the time from before any PPS load
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         vita_time_pps <= '0;
         pps_int_o     <= 1'b0;
         good_sync_o   <= 1'b0;
      end else begin
         pps_int_o <= pps_edge;
         if (pps_edge) begin
            vita_time_pps <= vita_time;
         end
         if (pps_load) begin
            good_sync_o <= 1'b1;
         end
      end
   end

   assign vita_time_o     = vita_time;
   assign vita_time_pps_o = vita_time_pps;

endmodule

`default_nettype wire

/* design/status_readback.sv */
/*
 * Registered readback mux over 16 status words.
 * The selected word is valid one cycle after rb_addr_i is sampled.
 */

`timescale 1ns/1ps
`default_nettype none

`include "u2_ctrl_defs.svh"

module status_readback
   import settings_pkg::*;
   import timing_pkg::*;
(
   input  wire         dsp_clk,
   input  wire         por_rst,
   input  rb_addr_t    rb_addr_i,
   input  wire  [31:0] status_i,
   input  vita_time_t  vita_time_i,
   input  vita_time_t  vita_time_pps_i,
   input  wire         clk_status_i,
   input  wire         serdes_link_up_i,
   input  wire         button_i,
   output logic [31:0] rb_data_o
);

   logic [31:0] board_bits;

   // Button at 13, clock status at 11, link at 10
   assign board_bits = {18'b0, button_i, 1'b0, clk_status_i, serdes_link_up_i, 10'b0};

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         rb_data_o <= '0;
      end else begin
         case (rb_addr_i)
            4'd0,
            4'd8:    rb_data_o <= status_i;
            4'd10:   rb_data_o <= vita_time_i[63:32];
            4'd11:   rb_data_o <= vita_time_i[31:0];
            4'd12:   rb_data_o <= `COMPAT_NUM;
            4'd13:   rb_data_o <= board_bits;
            4'd14:   rb_data_o <= vita_time_pps_i[63:32];
            4'd15:   rb_data_o <= vita_time_pps_i[31:0];
            // Word 9 was GPIO readback
            default: rb_data_o <= '0;
         endcase
      end
   end

endmodule

`default_nettype wire

/* design/u2_ctrl_core.sv */
/*
 * Top of the control and timing core. Settings writes enter through the
 * ingress stage, land in the misc and time registers, and status is read
 * back through a registered word mux.
 */

`timescale 1ns/1ps
`default_nettype none

module u2_ctrl_core
   import settings_pkg::*;
   import timing_pkg::*;
(
   input  wire         dsp_clk,
   input  wire         por_rst,
   // Settings bus
   input  wire         set_stb_i,
   input  set_addr_t   set_addr_i,
   input  set_data_t   set_data_i,
   // Board status
   input  wire         pps_i,
   input  wire         run_rx_i,
   input  wire         run_tx_i,
   input  wire         clk_status_i,
   input  wire         serdes_link_up_i,
   input  wire         button_i,
   input  wire  [31:0] status_i,
   // Readback
   input  rb_addr_t    rb_addr_i,
   output logic [31:0] rb_data_o,
   // Control outputs
   output ctrl_pins_t  ctrl_pins_o,
   output logic [7:0]  leds_o,
   output logic        phy_resetn_o,
   output logic        pps_int_o
);

   set_bus_t   set_bus;
   set_cmd_t   set_cmd;
   vita_time_t vita_time;
   vita_time_t vita_time_pps;
   logic       good_sync;

   assign set_bus.stb  = set_stb_i;
   assign set_bus.addr = set_addr_i;
   assign set_bus.data = set_data_i;

   ////////////////////
   // Stage 1
   ////////////////////

   settings_ingress ingress (
      .dsp_clk (dsp_clk),
      .por_rst (por_rst),
      .set_i   (set_bus),
      .cmd_o   (set_cmd)
   );

   ////////////////////
   // Stage 2
   ////////////////////

   misc_control misc (
      .dsp_clk          (dsp_clk),
      .por_rst          (por_rst),
      .cmd_i            (set_cmd),
      .run_rx_i         (run_rx_i),
      .run_tx_i         (run_tx_i),
      .clk_status_i     (clk_status_i),
      .serdes_link_up_i (serdes_link_up_i),
      .good_sync_i      (good_sync),
      .ctrl_pins_o      (ctrl_pins_o),
      .leds_o           (leds_o),
      .phy_resetn_o     (phy_resetn_o)
   );

   vita_time_keeper timekeeper (
      .dsp_clk         (dsp_clk),
      .por_rst         (por_rst),
      .cmd_i           (set_cmd),
      .pps_i           (pps_i),
      .vita_time_o     (vita_time),
      .vita_time_pps_o (vita_time_pps),
      .good_sync_o     (good_sync),
      .pps_int_o       (pps_int_o)
   );

   ////////////////////
   // Stage 3
   ////////////////////

   status_readback readback (
      .dsp_clk          (dsp_clk),
      .por_rst          (por_rst),
      .rb_addr_i        (rb_addr_i),
      .status_i         (status_i),
      .vita_time_i      (vita_time),
      .vita_time_pps_i  (vita_time_pps),
      .clk_status_i     (clk_status_i),
      .serdes_link_up_i (serdes_link_up_i),
      .button_i         (button_i),
      .rb_data_o        (rb_data_o)
   );

endmodule

`default_nettype wire

/* sim/u2_ctrl_properties.sv */
/*
 * Concurrent checks on the control core, bound onto u2_ctrl_core.
 * Covers the decoded write enables, the PPS interrupt and sync status.
 */

`timescale 1ns/1ps
`default_nettype none

module u2_ctrl_properties
   import settings_pkg::*;
(
   input wire      dsp_clk,
   input wire      por_rst,
   input set_cmd_t set_cmd,
   input wire      pps_int,
   input wire      good_sync,
   input wire      phy_resetn
);

   // A write lands in one bank at most
   one_bank_we: assert property (@(posedge dsp_clk) disable iff (por_rst)
      !(set_cmd.misc_we && set_cmd.time_we))
      else $error("misc and time write enables high together");

   pps_int_single: assert property (@(posedge dsp_clk) disable iff (por_rst)
      pps_int |=> !pps_int)
      else $error("PPS interrupt high for more than one cycle");

   // Sync is sticky until the next reset
   good_sync_held: assert property (@(posedge dsp_clk) disable iff (por_rst)
      good_sync |=> good_sync)
      else $error("good_sync fell outside reset");

   phy_out_of_reset: assert property (@(posedge dsp_clk)
      $fell(por_rst) |-> phy_resetn)
      else $error("PHY reset pin low right after reset");

endmodule

`default_nettype wire

/* sim/tb_u2_ctrl_core.sv */
/*
 * Directed testbench for the control and timing core. Each test task drives
 * settings writes and board inputs, then checks pins, LEDs and readback words
 * against the register map. The assertion module is bound onto the DUT here.
 */

`timescale 1ns/1ps
`default_nettype none

`include "u2_ctrl_defs.svh"

module tb_u2_ctrl_core
   import settings_pkg::*;
   import timing_pkg::*;
();

   // Rough sum of the cycles spent by all tests
   localparam int TEST_CYCLES     = 250;
   localparam int WATCHDOG_CYCLES = 100 * TEST_CYCLES;

   localparam set_addr_t ADDR_CLK     = `SR_MISC_BASE + 8'(`MISC_CLK);
   localparam set_addr_t ADDR_SER     = `SR_MISC_BASE + 8'(`MISC_SER);
   localparam set_addr_t ADDR_ADC     = `SR_MISC_BASE + 8'(`MISC_ADC);
   localparam set_addr_t ADDR_LED_SW  = `SR_MISC_BASE + 8'(`MISC_LED_SW);
   localparam set_addr_t ADDR_PHY     = `SR_MISC_BASE + 8'(`MISC_PHY);
   localparam set_addr_t ADDR_LED_SRC = `SR_MISC_BASE + 8'(`MISC_LED_SRC);
   localparam set_addr_t ADDR_TIME_HI = `SR_TIME64_BASE + 8'(`TIME_HI);
   localparam set_addr_t ADDR_TIME_LO = `SR_TIME64_BASE + 8'(`TIME_LO);
   localparam set_addr_t ADDR_CTRL    = `SR_TIME64_BASE + 8'(`TIME_CTRL);

   logic        dsp_clk;
   logic        por_rst;
   logic        set_stb_i;
   set_addr_t   set_addr_i;
   set_data_t   set_data_i;
   logic        pps_i;
   logic        run_rx_i;
   logic        run_tx_i;
   logic        clk_status_i;
   logic        serdes_link_up_i;
   logic        button_i;
   logic [31:0] status_i;
   rb_addr_t    rb_addr_i;
   logic [31:0] rb_data_o;
   ctrl_pins_t  ctrl_pins_o;
   logic [7:0]  leds_o;
   logic        phy_resetn_o;
   logic        pps_int_o;

   logic [31:0] lfsr_state;
   // Set once an armed PPS load has happened
   logic        synced;

   u2_ctrl_core uut (
      .dsp_clk          (dsp_clk),
      .por_rst          (por_rst),
      .set_stb_i        (set_stb_i),
      .set_addr_i       (set_addr_i),
      .set_data_i       (set_data_i),
      .pps_i            (pps_i),
      .run_rx_i         (run_rx_i),
      .run_tx_i         (run_tx_i),
      .clk_status_i     (clk_status_i),
      .serdes_link_up_i (serdes_link_up_i),
      .button_i         (button_i),
      .status_i         (status_i),
      .rb_addr_i        (rb_addr_i),
      .rb_data_o        (rb_data_o),
      .ctrl_pins_o      (ctrl_pins_o),
      .leds_o           (leds_o),
      .phy_resetn_o     (phy_resetn_o),
      .pps_int_o        (pps_int_o)
   );

   bind u2_ctrl_core u2_ctrl_properties props (
      .dsp_clk    (dsp_clk),
      .por_rst    (por_rst),
      .set_cmd    (set_cmd),
      .pps_int    (pps_int_o),
      .good_sync  (good_sync),
      .phy_resetn (phy_resetn_o)
   );

   initial dsp_clk = 1'b0;
   always #2 dsp_clk = ~dsp_clk;

   ////////////////////
   // Helpers
   ////////////////////

   function automatic logic [31:0] lfsr_next(input logic [31:0] state);
      return (state >> 1) ^ (state[0] ? 32'hD000_0001 : 32'h0);
   endfunction

   // One LFSR step per bit taken
   task automatic next_random(input int nbits, output logic [31:0] value);
      value = '0;
      for (int i = 0; i < nbits; i++) begin
         value = {value[30:0], lfsr_state[0]};
         lfsr_state = lfsr_next(lfsr_state);
      end
   endtask

   task automatic check_value(input string name, input logic [63:0] actual,
                              input logic [63:0] expected);
      if (actual !== expected) begin
         $display("[FAIL] t=%0t %s: got 0x%0h, expected 0x%0h",
                  $time, name, actual, expected);
         $display("*** FAILED ***");
         $fatal(1, "value mismatch on %s", name);
      end
   endtask

   // Source bit 1 shows the hardware status bit and 0 the software bit
   function automatic logic [7:0] led_expected(input logic [7:0] src, input logic [7:0] sw);
      logic [7:0] hw;
      logic [7:0] led;
      hw    = 8'h00;
      hw[4] = run_tx_i;
      hw[3] = run_rx_i;
      hw[2] = clk_status_i;
      hw[1] = serdes_link_up_i && synced;
      for (int i = 0; i < 8; i++) begin
         led[i] = src[i] ? hw[i] : sw[i];
      end
      return led;
   endfunction

   task automatic write_setting(input set_addr_t addr, input set_data_t data);
      @(posedge dsp_clk);
      set_stb_i  <= 1'b1;
      set_addr_i <= addr;
      set_data_i <= data;
      @(posedge dsp_clk);
      set_stb_i  <= 1'b0;
      repeat (2) @(posedge dsp_clk);
      @(negedge dsp_clk);
   endtask

   task automatic read_word(input rb_addr_t addr, output logic [31:0] data);
      @(posedge dsp_clk);
      rb_addr_i <= addr;
      repeat (2) @(posedge dsp_clk);
      @(negedge dsp_clk);
      data = rb_data_o;
   endtask

   task automatic wait_pps_int();
      int cycles;
      cycles = 0;
      while ((pps_int_o !== 1'b1) && (cycles < 50)) begin
         @(negedge dsp_clk);
         cycles++;
      end
      if (pps_int_o !== 1'b1) begin
         $display("ERROR: pps_int_o did not pulse within 50 cycles of the PPS edge");
         $display("*** FAILED ***");
         $fatal(1, "PPS interrupt timeout");
      end
   endtask

   task automatic pulse_pps();
      @(posedge dsp_clk);
      pps_i <= 1'b1;
      wait_pps_int();
      @(posedge dsp_clk);
      pps_i <= 1'b0;
      repeat (4) @(posedge dsp_clk);
   endtask

   ////////////////////
   // Tests
   ////////////////////

   task automatic test_reset_values();
      logic [31:0] word;
      check_value("ctrl_pins_o", 64'(ctrl_pins_o), 64'd0);
      check_value("phy_resetn_o", 64'(phy_resetn_o), 64'd1);
      check_value("pps_int_o", 64'(pps_int_o), 64'd0);
      check_value("leds_o", 64'(leds_o), 64'(led_expected(`LED_SRC_RESET, 8'h00)));
      read_word(4'd11, word);
      check_value("rb word 11 at most 20 after reset", 64'(word <= 32'd20), 64'd1);
   endtask

   task automatic test_misc_registers();
      logic [31:0] clk_word;
      logic [31:0] ser_word;
      logic [31:0] adc_word;
      logic [31:0] junk;
      logic [12:0] pins;
      pins = '0;
      for (int round = 0; round < 3; round++) begin
         next_random(32, clk_word);
         next_random(32, ser_word);
         next_random(32, adc_word);
         write_setting(ADDR_CLK, clk_word);
         write_setting(ADDR_SER, ser_word);
         write_setting(ADDR_ADC, adc_word);
         // Clock fields sit on top of the struct and ADC fields at the bottom
         pins = {clk_word[4:0], ser_word[3:0], adc_word[3:0]};
         check_value("ctrl_pins_o", 64'(ctrl_pins_o), 64'(pins));
      end
      write_setting(ADDR_PHY, 32'd1);
      check_value("phy_resetn_o", 64'(phy_resetn_o), 64'd0);
      write_setting(ADDR_PHY, 32'd0);
      check_value("phy_resetn_o", 64'(phy_resetn_o), 64'd1);
      // Address 7 lies past the misc bank
      next_random(32, junk);
      write_setting(8'd7, junk);
      check_value("ctrl_pins_o", 64'(ctrl_pins_o), 64'(pins));
      check_value("phy_resetn_o", 64'(phy_resetn_o), 64'd1);
      check_value("leds_o", 64'(leds_o), 64'(led_expected(`LED_SRC_RESET, 8'h00)));
   endtask

   task automatic test_led_mux();
      logic [31:0] src;
      logic [31:0] sw;
      logic [31:0] inputs;
      for (int round = 0; round < 6; round++) begin
         next_random(8, src);
         next_random(8, sw);
         next_random(4, inputs);
         @(posedge dsp_clk);
         run_rx_i         <= inputs[0];
         run_tx_i         <= inputs[1];
         clk_status_i     <= inputs[2];
         serdes_link_up_i <= inputs[3];
         write_setting(ADDR_LED_SRC, src);
         write_setting(ADDR_LED_SW, sw);
         check_value("leds_o", 64'(leds_o), 64'(led_expected(src[7:0], sw[7:0])));
      end
   endtask

   task automatic test_time_load_now();
      logic [31:0] hi;
      logic [31:0] lo;
      logic [31:0] word;
      logic [31:0] status_word;
      logic [31:0] btn;
      logic [31:0] board;
      next_random(32, hi);
      // Top bit clear so the count cannot carry into the high word
      next_random(31, lo);
      write_setting(ADDR_TIME_HI, hi);
      write_setting(ADDR_TIME_LO, lo);
      write_setting(ADDR_CTRL, 32'd1);
      read_word(4'd10, word);
      check_value("rb word 10 time high", 64'(word), 64'(hi));
      read_word(4'd11, word);
      check_value("rb word 11 within 20 of loaded low",
                  64'((word >= lo) && (word <= lo + 32'd20)), 64'd1);
      read_word(4'd12, word);
      check_value("rb word 12 compat number", 64'(word), 64'(`COMPAT_NUM));
      next_random(32, status_word);
      next_random(1, btn);
      @(posedge dsp_clk);
      status_i <= status_word;
      button_i <= btn[0];
      read_word(4'd0, word);
      check_value("rb word 0 status", 64'(word), 64'(status_word));
      read_word(4'd8, word);
      check_value("rb word 8 status", 64'(word), 64'(status_word));
      board     = '0;
      board[13] = btn[0];
      board[11] = clk_status_i;
      board[10] = serdes_link_up_i;
      read_word(4'd13, word);
      check_value("rb word 13 board bits", 64'(word), 64'(board));
      read_word(4'd9, word);
      check_value("rb word 9", 64'(word), 64'd0);
   endtask

   task automatic test_pps_load();
      logic [31:0] hi;
      logic [31:0] lo;
      logic [31:0] word;
      logic [31:0] word_lo;
      vita_time_t  loaded;
      @(posedge dsp_clk);
      serdes_link_up_i <= 1'b1;
      write_setting(ADDR_LED_SRC, 32'(`LED_SRC_RESET));
      next_random(32, hi);
      next_random(31, lo);
      loaded = {hi, lo};
      write_setting(ADDR_TIME_HI, hi);
      write_setting(ADDR_TIME_LO, lo);
      write_setting(ADDR_CTRL, 32'd0);
      pulse_pps();
      synced = 1'b1;
      read_word(4'd10, word);
      check_value("rb word 10 time high after PPS load", 64'(word), 64'(hi));
      check_value("leds_o[1] good sync", 64'(leds_o[1]), 64'd1);
      // Second edge captures a time counted on from the load
      pulse_pps();
      read_word(4'd14, word);
      read_word(4'd15, word_lo);
      check_value("PPS time at or after loaded time",
                  64'({word, word_lo} >= loaded), 64'd1);
   endtask

   ////////////////////
   // Run control
   ////////////////////

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge dsp_clk);
      $display("ERROR: watchdog expired before the tests finished");
      $display("*** FAILED ***");
      $fatal(1, "watchdog timeout");
   end

   initial begin
      lfsr_state = 32'h614;
      synced     = 1'b0;
      por_rst          <= 1'b1;
      set_stb_i        <= 1'b0;
      set_addr_i       <= '0;
      set_data_i       <= '0;
      pps_i            <= 1'b0;
      // Status inputs high so the reset LED pattern shows the source mask
      run_rx_i         <= 1'b1;
      run_tx_i         <= 1'b1;
      clk_status_i     <= 1'b1;
      serdes_link_up_i <= 1'b1;
      button_i         <= 1'b0;
      status_i         <= '0;
      rb_addr_i        <= '0;
      repeat (5) @(posedge dsp_clk);
      por_rst <= 1'b0;
      @(negedge dsp_clk);
      test_reset_values();
      test_misc_registers();
      test_led_mux();
      test_time_load_now();
      test_pps_load();
      $display("*** PASSED ***");
      $finish;
   end

endmodule

`default_nettype wire

/* compile.f */
+incdir+common
common/settings_pkg.sv
common/timing_pkg.sv
design/settings_ingress.sv
design/misc_control.sv
time/vita_time_keeper.sv
design/status_readback.sv
design/u2_ctrl_core.sv
sim/u2_ctrl_properties.sv
sim/tb_u2_ctrl_core.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the u2_ctrl_core testbench with Verilator.
# Pass or fail comes from searching the log for the fail message.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
   -f compile.f --top-module tb_u2_ctrl_core \
   -Mdir obj_dir -o tb_u2_ctrl_core
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/tb_u2_ctrl_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q '\*\*\* FAILED \*\*\*' "$LOG"; then
   exit 1
fi
exit 0
